//--- hw/fan_pwm.sv
`timescale 1ns/1ps

module fan_pwm (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] speed_i,
  output logic        fan_o
);

  logic [15:0] cnt_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
      fan_o <= 1'b0;
    end else begin
      if (cnt_q >= speed_i[31:16]) cnt_q <= '0;  // Period minus one in upper half
      else cnt_q <= cnt_q + 16'd1;
      fan_o <= (cnt_q < speed_i[15:0]);
    end
  end

endmodule

//--- hw/io_controller.sv
`timescale 1ns/1ps

module io_controller (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     cyc_i,
  input  logic                     stb_i,
  input  logic                     we_i,
  input  logic [3:0]               sel_i,
  input  logic [io_pkg::BUS_AW-1:0] adr_i,
  input  logic [31:0]              dat_i,
  output logic [31:0]              dat_o,
  output logic                     ack_o,
  output logic                     tx0_o,
  input  logic                     rx0_i,
  input  logic                     cts0_i,
  output logic                     rts0_o,
  output logic                     tx1_o,
  output logic                     fan_o,
  input  logic [15:0]              sw_i,
  output logic [8:0]               led_o,
  output logic [55:0]              hex_o,
  output logic [3:0]               interrupts_o
);
  import io_pkg::*;

  logic [1:0]           state_q, state_d;
  logic [31:0]          result_q, result_d;
  logic [31:0]          seg_q, seg_d;
  logic [31:0]          fan_q, fan_d;
  logic [8:0]           led_d;
  logic [31:0]          led_word;
  logic [3:0]           slot;
  logic [REG_IDX_W-1:0] reg_idx;

  logic        cyc_bus;
  logic        stb_uart0, stb_uart1, stb_timer;
  logic [31:0] uart0_dat, uart1_dat, timer_dat;
  logic        uart0_ack, uart1_ack, timer_ack;
  logic [1:0]  uart0_irq, timer_irq;

  function automatic logic [31:0] lane_merge(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  assign slot    = adr_i[15:12];
  assign reg_idx = adr_i[3:2];
  assign ack_o   = (state_q == ST_DONE);
  assign dat_o   = result_q;

  assign cyc_bus   = (state_q == ST_BUSY);  // Shared cyc to peripherals
  assign stb_uart0 = (slot == SEL_UART0);
  assign stb_uart1 = (slot == SEL_UART1);
  assign stb_timer = (slot == SEL_TIMER);

  assign interrupts_o = {timer_irq, uart0_irq};

  always_comb begin
    state_d  = state_q;
    result_d = result_q;
    seg_d    = seg_q;
    fan_d    = fan_q;
    led_d    = led_o;
    led_word = lane_merge({23'b0, led_o}, dat_i, sel_i);
    case (state_q)
      ST_IDLE: begin
        if (cyc_i && stb_i) state_d = ST_BUSY;
      end
      ST_BUSY: begin
        case (slot)
          SEL_LOCAL: begin
            if (we_i) begin
              if (reg_idx == REG_SEG) seg_d = lane_merge(seg_q, dat_i, sel_i);
              else if (reg_idx == REG_FAN) fan_d = lane_merge(fan_q, dat_i, sel_i);
            end else begin
              case (reg_idx)
                REG_SEG: result_d = seg_q;
                REG_FAN: result_d = fan_q;
                default: result_d = '0;
              endcase
            end
            state_d = ST_DONE;
          end
          SEL_LEDSW: begin
            if (we_i) led_d = led_word[8:0];
            else result_d = {16'h0000, sw_i};
            state_d = ST_DONE;
          end
          SEL_UART0: begin
            if (!we_i) result_d = uart0_dat;
            if (uart0_ack) state_d = ST_DONE;
          end
          SEL_UART1: begin
            if (!we_i) result_d = uart1_dat;
            if (uart1_ack) state_d = ST_DONE;
          end
          SEL_TIMER: begin
            if (!we_i) result_d = timer_dat;
            if (timer_ack) state_d = ST_DONE;
          end
          default: begin  // Unmapped slots
            if (!we_i) result_d = '0;
            state_d = ST_DONE;
          end
        endcase
      end
      ST_DONE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q  <= ST_IDLE;
      result_q <= '0;
      seg_q    <= '0;
      fan_q    <= FAN_RESET;
      led_o    <= '0;
    end else begin
      state_q  <= state_d;
      result_q <= result_d;
      seg_q    <= seg_d;
      fan_q    <= fan_d;
      led_o    <= led_d;
    end
  end

  uart #(.DIV(UART0_DIV), .RX_EN(1'b1)) uart0 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .cyc_i  (cyc_bus),
    .stb_i  (stb_uart0),
    .we_i   (we_i),
    .adr_i  (reg_idx),
    .dat_i  (dat_i),
    .dat_o  (uart0_dat),
    .ack_o  (uart0_ack),
    .tx_o   (tx0_o),
    .rx_i   (rx0_i),
    .cts_i  (cts0_i),
    .rts_o  (rts0_o),
    .irq_o  (uart0_irq)
  );

  // Transmit only, always clear to send
  uart #(.DIV(UART1_DIV), .RX_EN(1'b0)) uart1 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .cyc_i  (cyc_bus),
    .stb_i  (stb_uart1),
    .we_i   (we_i),
    .adr_i  (reg_idx),
    .dat_i  (dat_i),
    .dat_o  (uart1_dat),
    .ack_o  (uart1_ack),
    .tx_o   (tx1_o),
    .rx_i   (1'b1),
    .cts_i  (1'b0),
    .rts_o  (),
    .irq_o  ()
  );

  timer_int timer0 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .cyc_i  (cyc_bus),
    .stb_i  (stb_timer),
    .we_i   (we_i),
    .adr_i  (reg_idx),
    .dat_i  (dat_i),
    .dat_o  (timer_dat),
    .ack_o  (timer_ack),
    .irq_o  (timer_irq)
  );

  fan_pwm fan0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .speed_i (fan_q),
    .fan_o   (fan_o)
  );

  seg_digits seg0 (
    .value_i (seg_q),
    .hex_o   (hex_o)
  );

endmodule

//--- hw/io_pkg.sv
package io_pkg;

  // Bus
  localparam int BUS_AW    = 16;
  localparam int REG_IDX_W = 2;  // Register index from adr_i[3:2]

  // Slot codes on adr_i[15:12]
  localparam logic [3:0] SEL_LOCAL = 4'h0;
  localparam logic [3:0] SEL_LEDSW = 4'h1;
  localparam logic [3:0] SEL_UART0 = 4'h2;
  localparam logic [3:0] SEL_UART1 = 4'h3;
  localparam logic [3:0] SEL_TIMER = 4'h8;

  // Local slot registers
  localparam logic [REG_IDX_W-1:0] REG_SEG = 2'd0;
  localparam logic [REG_IDX_W-1:0] REG_FAN = 2'd1;

  // UART registers
  localparam logic [REG_IDX_W-1:0] UART_REG_DATA   = 2'd0;
  localparam logic [REG_IDX_W-1:0] UART_REG_STATUS = 2'd1;

  // Timer registers
  localparam logic [REG_IDX_W-1:0] TMR_REG_COUNT0 = 2'd0;
  localparam logic [REG_IDX_W-1:0] TMR_REG_COUNT1 = 2'd1;
  localparam logic [REG_IDX_W-1:0] TMR_REG_CTRL   = 2'd2;

  // Fan word is {period - 1, duty}
  localparam logic [31:0] FAN_RESET = 32'h000F_0000;

  // Clocks per bit
  localparam int UART0_DIV = 16;
  localparam int UART1_DIV = 32;

  // Bus sequencer states
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_BUSY = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

endpackage

//--- hw/seg_digits.sv
`timescale 1ns/1ps

module seg_digits (
  input  logic [31:0] value_i,
  output logic [55:0] hex_o
);

  // Segments gfedcba, low lights
  function automatic logic [6:0] seg_of(input logic [3:0] nib);
    case (nib)
      4'h0:    seg_of = 7'h40;
      4'h1:    seg_of = 7'h79;
      4'h2:    seg_of = 7'h24;
      4'h3:    seg_of = 7'h30;
      4'h4:    seg_of = 7'h19;
      4'h5:    seg_of = 7'h12;
      4'h6:    seg_of = 7'h02;
      4'h7:    seg_of = 7'h78;
      4'h8:    seg_of = 7'h00;
      4'h9:    seg_of = 7'h10;
      4'hA:    seg_of = 7'h08;
      4'hB:    seg_of = 7'h03;
      4'hC:    seg_of = 7'h46;
      4'hD:    seg_of = 7'h21;
      4'hE:    seg_of = 7'h06;
      default: seg_of = 7'h0E;
    endcase
  endfunction

  for (genvar d = 0; d < 8; d++) begin : g_digit
    assign hex_o[7*d +: 7] = seg_of(value_i[4*d +: 4]);  // Digit 0 at the bottom
  end

endmodule

//--- hw/timer_int.sv
`timescale 1ns/1ps

module timer_int (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [io_pkg::REG_IDX_W-1:0] adr_i,
  input  logic [31:0]                 dat_i,
  output logic [31:0]                 dat_o,
  output logic                        ack_o,
  output logic [1:0]                  irq_o
);
  import io_pkg::*;

  logic [31:0] reload_q [2];
  logic [31:0] count_q [2];
  logic [1:0]  en_q, flag_q;
  logic        access, wr_ctrl;

  assign access  = cyc_i & stb_i & ~ack_o;
  assign wr_ctrl = access & we_i & (adr_i == TMR_REG_CTRL);
  assign irq_o   = flag_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) ack_o <= 1'b0;
    else ack_o <= cyc_i & stb_i;
  end

  always_ff @(posedge clk_i) begin
    if (access && we_i && adr_i == TMR_REG_COUNT0) reload_q[0] <= dat_i;
    if (access && we_i && adr_i == TMR_REG_COUNT1) reload_q[1] <= dat_i;
    if (access && !we_i) begin
      case (adr_i)
        TMR_REG_COUNT0: dat_o <= reload_q[0];
        TMR_REG_COUNT1: dat_o <= reload_q[1];
        TMR_REG_CTRL:   dat_o <= {22'b0, flag_q, 6'b0, en_q};
        default:        dat_o <= '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      en_q       <= '0;
      flag_q     <= '0;
      count_q[0] <= '0;
      count_q[1] <= '0;
    end else begin
      if (wr_ctrl) en_q <= dat_i[1:0];
      for (int i = 0; i < 2; i++) begin
        if (wr_ctrl && dat_i[i] && !en_q[i]) begin
          count_q[i] <= reload_q[i];  // Fresh start on enable
        end else if (en_q[i]) begin
          if (count_q[i] == '0) count_q[i] <= reload_q[i];
          else count_q[i] <= count_q[i] - 32'd1;
        end
        // Set wins over write-one-to-clear
        flag_q[i] <= (en_q[i] && count_q[i] == '0) ||
                     (flag_q[i] && !(wr_ctrl && dat_i[8+i]));
      end
    end
  end

endmodule

//--- hw/uart.sv
`timescale 1ns/1ps

module uart #(
  parameter int DIV   = 16,
  parameter bit RX_EN = 1'b1
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [io_pkg::REG_IDX_W-1:0] adr_i,
  input  logic [31:0]                 dat_i,
  output logic [31:0]                 dat_o,
  output logic                        ack_o,
  output logic                        tx_o,
  input  logic                        rx_i,
  input  logic                        cts_i,
  output logic                        rts_o,
  output logic [1:0]                  irq_o
);
  import io_pkg::*;

  logic       access, wr_data, rd_data;
  logic [7:0] tx_data;
  logic       tx_pend, tx_active, tx_done, tx_busy;
  logic [9:0] tx_shift;
  logic [3:0] tx_bits;
  logic [15:0] tx_div;
  logic       rx_ready, rx_overrun;
  logic [7:0] rx_data;

  assign access  = cyc_i & stb_i & ~ack_o;  // First cycle of a transfer
  assign wr_data = access & we_i & (adr_i == UART_REG_DATA);
  assign rd_data = access & ~we_i & (adr_i == UART_REG_DATA);
  assign tx_busy = tx_pend | tx_active;
  assign tx_o    = tx_shift[0];
  assign irq_o   = {tx_done, rx_ready};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) ack_o <= 1'b0;
    else ack_o <= cyc_i & stb_i;
  end

  always_ff @(posedge clk_i) begin
    if (access && !we_i) begin
      if (adr_i == UART_REG_STATUS) dat_o <= {29'b0, rx_overrun, tx_busy, rx_ready};
      else if (adr_i == UART_REG_DATA) dat_o <= {24'b0, rx_data};
      else dat_o <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_data && !tx_busy) tx_data <= dat_i[7:0];
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      tx_pend   <= 1'b0;
      tx_active <= 1'b0;
      tx_done   <= 1'b0;
      tx_shift  <= '1;  // Line idles high
      tx_bits   <= '0;
      tx_div    <= '0;
    end else begin
      if (wr_data && !tx_busy) begin
        tx_pend <= 1'b1;
        tx_done <= 1'b0;
      end else if (tx_pend && !cts_i) begin  // Start once clear to send
        tx_pend   <= 1'b0;
        tx_active <= 1'b1;
        tx_shift  <= {1'b1, tx_data, 1'b0};
        tx_bits   <= 4'd10;
        tx_div    <= 16'(DIV - 1);
      end else if (tx_active) begin
        if (tx_div == '0) begin
          tx_div   <= 16'(DIV - 1);
          tx_shift <= {1'b1, tx_shift[9:1]};
          tx_bits  <= tx_bits - 4'd1;
          if (tx_bits == 4'd1) begin  // End of stop bit
            tx_active <= 1'b0;
            tx_done   <= 1'b1;
          end
        end else begin
          tx_div <= tx_div - 16'd1;
        end
      end
    end
  end

  if (RX_EN) begin : g_rx
    logic        rx_s1, rx_s2, rx_active, rx_done, rx_tick;
    logic [3:0]  rx_bit;
    logic [15:0] rx_div;
    logic [7:0]  rx_shift;

    assign rx_tick = rx_active && (rx_div == '0);
    assign rx_done = rx_tick && (rx_bit == 4'd9) && rx_s2;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        rx_s1      <= 1'b1;
        rx_s2      <= 1'b1;
        rx_active  <= 1'b0;
        rx_bit     <= '0;
        rx_div     <= '0;
        rx_ready   <= 1'b0;
        rx_overrun <= 1'b0;
      end else begin
        rx_s1 <= rx_i;
        rx_s2 <= rx_s1;
        if (!rx_active) begin
          if (!rx_s2) begin
            rx_active <= 1'b1;
            rx_bit    <= '0;
            rx_div    <= 16'(DIV / 2 - 1);  // Land in mid start bit
          end
        end else if (rx_div != '0) begin
          rx_div <= rx_div - 16'd1;
        end else begin
          rx_div <= 16'(DIV - 1);
          rx_bit <= rx_bit + 4'd1;
          if ((rx_bit == '0 && rx_s2) || rx_bit == 4'd9) rx_active <= 1'b0;
        end
        if (rx_done) begin
          rx_ready   <= 1'b1;
          rx_overrun <= rx_overrun | (rx_ready & ~rd_data);
        end else if (rd_data) begin
          rx_ready   <= 1'b0;
          rx_overrun <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (rx_tick && rx_bit >= 4'd1 && rx_bit <= 4'd8) rx_shift <= {rx_s2, rx_shift[7:1]};
      if (rx_done) rx_data <= rx_shift;
    end
  end else begin : g_no_rx
    assign rx_ready   = 1'b0;
    assign rx_overrun = 1'b0;
    assign rx_data    = '0;
  end

  // Not ready to take a byte while one is held
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) rts_o <= 1'b1;
    else rts_o <= rx_ready;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the io_controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module io_controller_tb -o io_sim

out=$(./obj_dir/io_sim)
echo "$out"
echo "$out" | grep -q "^No errors$"

//--- sim/io_controller_tb.sv
`timescale 1ns/1ps

module io_controller_tb;
  import io_pkg::*;

  localparam int MAX_CYCLES = 20000;  // Longest poll is about two UART frames
  // Active-low gfedcba patterns for hex 0 to F
  localparam logic [6:0] SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic              clk_i, rst_i;
  logic              cyc_i, stb_i, we_i;
  logic [3:0]        sel_i;
  logic [BUS_AW-1:0] adr_i;
  logic [31:0]       dat_i, dat_o;
  logic              ack_o;
  logic              tx0_o, rx0_i, cts0_i, rts0_o, tx1_o, fan_o;
  logic [15:0]       sw_i;
  logic [8:0]        led_o;
  logic [55:0]       hex_o;
  logic [3:0]        interrupts_o;

  int errors;
  int cycles = 0;
  int seed;

  assign rx0_i = tx0_o;  // UART0 loopback

  io_controller io_controller_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cyc_i        (cyc_i),
    .stb_i        (stb_i),
    .we_i         (we_i),
    .sel_i        (sel_i),
    .adr_i        (adr_i),
    .dat_i        (dat_i),
    .dat_o        (dat_o),
    .ack_o        (ack_o),
    .tx0_o        (tx0_o),
    .rx0_i        (rx0_i),
    .cts0_i       (cts0_i),
    .rts0_o       (rts0_o),
    .tx1_o        (tx1_o),
    .fan_o        (fan_o),
    .sw_i         (sw_i),
    .led_o        (led_o),
    .hex_o        (hex_o),
    .interrupts_o (interrupts_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run passed %0d cycles, a transfer or poll never finished", cycles);
      $display("Error count: %0d", errors);
      $display("Errors found");
      $finish;
    end
  end

  function automatic logic [55:0] expect_hex(input logic [31:0] value);
    logic [55:0] h;
    for (int d = 0; d < 8; d++) h[7*d +: 7] = SEG_TABLE[value[4*d +: 4]];
    return h;
  endfunction

  // One single transfer, returns at +10 ns after the ack edge
  task automatic bus_cycle(input logic we, input logic [BUS_AW-1:0] adr,
                           input logic [31:0] dat, input logic [3:0] sel,
                           output logic [31:0] rd);
    @(posedge clk_i);
    #10;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = adr;
    dat_i = dat;
    sel_i = sel;
    @(posedge clk_i);
    #10;
    while (!ack_o) begin
      @(posedge clk_i);
      #10;
    end
    rd    = dat_o;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic run_stim(input int fd);
    int                c, n, win, highs, waited;
    logic [7:0]        ch;
    logic [BUS_AW-1:0] adr;
    logic [31:0]       dat, mask, rd;
    logic [3:0]        sel;
    logic [63:0]       fan_seen;
    logic [8*200-1:0]  rest;
    c = $fgetc(fd);
    while (c != -1) begin
      ch = c[7:0];
      if (ch == "#") begin
        n = $fgets(rest, fd);  // Comment line
      end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
        n = $fscanf(fd, "%h %h %h %h", adr, dat, sel, mask);
        case (ch)
          "W": bus_cycle(1'b1, adr, dat, sel, rd);
          "R": begin
            bus_cycle(1'b0, adr, dat, sel, rd);
            if ((rd & mask) !== dat) begin
              errors++;
              $display("** Error at time %0t: read 0x%h from 0x%h, expected 0x%h",
                       $time, rd & mask, adr, dat);
            end
          end
          "P": begin
            bus_cycle(1'b0, adr, dat, sel, rd);
            while ((rd & mask) !== dat) bus_cycle(1'b0, adr, dat, sel, rd);
          end
          "C": begin
            repeat (dat) @(posedge clk_i);
            #10;
          end
          "X": if (hex_o !== expect_hex(dat)) begin
            errors++;
            $display("** Error at time %0t: hex_o is 0x%h, expected 0x%h",
                     $time, hex_o, expect_hex(dat));
          end
          "L": if (led_o !== dat[8:0]) begin
            errors++;
            $display("** Error at time %0t: led_o is 0x%h, expected 0x%h",
                     $time, led_o, dat[8:0]);
          end
          "I": begin
            if ((interrupts_o & mask[3:0]) !== dat[3:0]) begin
              errors++;
              $display("** Error at time %0t: interrupts_o is 0x%h, expected 0x%h under 0x%h",
                       $time, interrupts_o, dat[3:0], mask[3:0]);
            end
            // RTS is high exactly while a received byte is held
            if (mask[0] && rts0_o !== dat[0]) begin
              errors++;
              $display("** Error at time %0t: rts0_o is %b, expected %b",
                       $time, rts0_o, dat[0]);
            end
          end
          "S": begin
            sw_i = 16'($random(seed));
            bus_cycle(1'b0, adr, dat, sel, rd);
            if (rd !== {16'h0000, sw_i}) begin
              errors++;
              $display("** Error at time %0t: switch read 0x%h, expected 0x%h",
                       $time, rd, {16'h0000, sw_i});
            end
          end
          "F": begin
            win = int'(mask);
            for (int i = 0; i < 4 * win; i++) begin
              @(posedge clk_i);
              #10;
              fan_seen[i] = fan_o;
            end
            for (int s = 0; s <= 3 * win; s++) begin  // Every window of one period
              highs = 0;
              for (int j = s; j < s + win; j++) if (fan_seen[j]) highs++;
              if (highs != int'(dat)) begin
                errors++;
                $display("** Error at time %0t: fan_o high %0d of %0d cycles, expected %0d",
                         $time, highs, win, dat);
              end
            end
          end
          "T": begin
            waited = 0;
            while (tx1_o && waited < int'(dat)) begin
              @(posedge clk_i);
              #10;
              waited++;
            end
            if (tx1_o) begin
              errors++;
              $display("UART1 start bit did not appear within %0d cycles of the write", dat);
            end
          end
          default: begin
            errors++;
            $display("Unknown command '%c' in the stimulus file", ch);
          end
        endcase
      end
      c = $fgetc(fd);
    end
  endtask

  initial begin
    int fd;
    errors = 0;
    seed   = 21;
    rst_i  = 1'b1;
    cyc_i  = 1'b0;
    stb_i  = 1'b0;
    we_i   = 1'b0;
    sel_i  = 4'h0;
    adr_i  = '0;
    dat_i  = '0;
    cts0_i = 1'b0;  // Always clear to send
    sw_i   = 16'($random(seed));
    repeat (3) @(posedge clk_i);
    #10;
    rst_i = 1'b0;

    if (ack_o !== 1'b0 || led_o !== 9'h000 || interrupts_o !== 4'h0 || fan_o !== 1'b0) begin
      errors++;
      $display("** Error at time %0t: ack_o, led_o, interrupts_o or fan_o not low after reset",
               $time);
    end
    if (tx0_o !== 1'b1 || tx1_o !== 1'b1 || rts0_o !== 1'b1) begin
      errors++;
      $display("** Error at time %0t: tx0_o, tx1_o or rts0_o not high after reset", $time);
    end
    if (hex_o !== expect_hex(32'h0)) begin
      errors++;
      $display("** Error at time %0t: hex_o is 0x%h after reset", $time, hex_o);
    end

    fd = $fopen("sim/io_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file sim/io_stim.txt");
    end else begin
      run_stim(fd);
      $fclose(fd);
    end

    $display("Error count: %0d", errors);
    if (errors == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

endmodule

//--- sim/io_stim.txt
# cmd addr data sel mask, all hex; R and P compare read & mask with data
# C wait data cycles, X hex_o for seg value data, L led_o, I irq under mask, S switch read, F fan window mask highs data, T tx1 start within data cycles
W 0000 12345678 f 00000000
R 0000 12345678 f ffffffff
X 0000 12345678 0 00000000
W 0000 0000ab00 2 00000000
R 0000 1234ab78 f ffffffff
W 0000 cdef0000 c 00000000
R 0000 cdefab78 f ffffffff
X 0000 cdefab78 0 00000000
W 1000 000001a5 f 00000000
L 0000 000001a5 0 00000000
W 1000 0000ffff 1 00000000
L 0000 000001ff 0 00000000
S 1000 00000000 f 00000000
W 0004 00070003 f 00000000
C 0000 00000020 0 00000000
F 0000 00000003 0 00000008
W 2000 000000a5 1 00000000
P 2004 00000001 f 00000001
I 0000 00000001 0 00000001
R 2000 000000a5 f 000000ff
R 2004 00000000 f 00000001
I 0000 00000000 0 00000001
P 2004 00000000 f 00000002
W 2000 0000003c 1 00000000
P 2004 00000001 f 00000001
P 2004 00000000 f 00000002
W 2000 0000005a 1 00000000
P 2004 00000004 f 00000004
R 2004 00000005 f 00000005
R 2000 0000005a f 000000ff
R 2004 00000000 f 00000005
W 8000 00000028 f 00000000
R 8000 00000028 f ffffffff
W 8008 00000001 f 00000000
P 8008 00000100 f 00000100
I 0000 00000004 0 0000000c
R 8008 00000101 f 00000303
W 8008 00000000 f 00000000
W 8008 00000100 f 00000000
R 8008 00000000 f 00000303
I 0000 00000000 0 0000000c
W 8004 00000005 f 00000000
C 0000 00000028 0 00000000
I 0000 00000000 0 00000008
R 8008 00000000 f 00000200
R 0000 cdefab78 f ffffffff
R 5000 00000000 f ffffffff
W 3000 00000055 1 00000000
T 0000 00000080 0 00000000

//--- sources.f
hw/io_pkg.sv
hw/fan_pwm.sv
hw/seg_digits.sv
hw/uart.sv
hw/timer_int.sv
hw/io_controller.sv
sim/io_controller_tb.sv
